/* hw/lsu_macros.svh */
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

////////////////////////////////////////////////////////////
// data side bus geometry
////////////////////////////////////////////////////////////

// data and address width of the core bus
`define LSU_XLEN   32

// byte lanes per bus word, also the byte enable width
`define LSU_NBYTES 4

////////////////////////////////////////////////////////////
// transaction tracking
////////////////////////////////////////////////////////////

// max transactions in flight, must fit the 2 bit counter
`define LSU_DEPTH  2

`endif

/* hw/lsu_pkg.sv */
`default_nettype none

`include "lsu_macros.svh"

package lsu_pkg;

  // access size as driven by the decoder
  typedef enum logic [1:0] {
    LSU_WORD     = 2'b00,
    LSU_HALF     = 2'b01,
    LSU_BYTE     = 2'b10,   // byte
    LSU_BYTE_ALT = 2'b11    // byte, second encoding
  } lsu_type_e;

  // load extension mode
  typedef enum logic [1:0] {
    LSU_EXT_ZERO     = 2'b00,
    LSU_EXT_SIGN     = 2'b01,
    LSU_EXT_ONES     = 2'b10,   // upper bits filled with ones
    LSU_EXT_SIGN_ALT = 2'b11    // sign, second encoding
  } lsu_ext_e;

  // one response word, seen as byte lanes or as halfword lanes
  typedef union packed {
    logic [`LSU_NBYTES-1:0][7:0]    b;   // b[0] is the lowest byte
    logic [`LSU_NBYTES/2-1:0][15:0] h;   // h[1] is the upper halfword
  } lsu_word_u;

endpackage

`default_nettype wire

/* hw/lsu_req_builder.sv */
`default_nettype none
`timescale 1ns/1ns

`include "lsu_macros.svh"

module lsu_req_builder (
  input  wire logic [`LSU_XLEN-1:0]   operand_a_i,       // base register
  input  wire logic [`LSU_XLEN-1:0]   operand_b_i,       // immediate or increment
  input  wire logic                   addr_useincr_i,    // 1: a + b, 0: a only
  input  wire lsu_pkg::lsu_type_e     data_type_i,       // word, half or byte
  input  wire logic [`LSU_XLEN-1:0]   data_wdata_i,      // store data as held in the register
  input  wire logic [1:0]             data_reg_offset_i, // byte offset of the data in the register
  output logic      [`LSU_XLEN-1:0]   addr_o,            // byte address to the bus
  output logic      [`LSU_NBYTES-1:0] be_o,              // byte enables to the bus
  output logic      [`LSU_XLEN-1:0]   wdata_o            // store data moved into its lanes
);

  import lsu_pkg::*;

  logic [1:0] addr_lsb;     // byte offset inside the bus word
  logic [1:0] wdata_shift;  // lanes to move the store data up by

  ////////////////////////////////////////////////////////////
  // address
  ////////////////////////////////////////////////////////////

  assign addr_o   = addr_useincr_i ? (operand_a_i + operand_b_i) : operand_a_i;
  assign addr_lsb = addr_o[1:0];

  ////////////////////////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////////////////////////

  // misaligned words and halfwords never get here, see the tracker check
  always_comb
  begin
    case (data_type_i)
      LSU_WORD:
      begin
        be_o = {`LSU_NBYTES{1'b1}};                           // all four lanes
      end
      LSU_HALF:
      begin
        be_o = {{(`LSU_NBYTES-2){1'b0}}, 2'b11} << addr_lsb;  // two lanes from the offset
      end
      LSU_BYTE,
      LSU_BYTE_ALT:
      begin
        be_o = {{(`LSU_NBYTES-1){1'b0}}, 1'b1} << addr_lsb;   // single lane
      end
      default:
      begin
        be_o = '0;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // store data lane rotation
  ////////////////////////////////////////////////////////////

  // distance from where the data sits in the register to where it goes on the bus
  assign wdata_shift = addr_lsb - data_reg_offset_i;  // wraps mod 4

  always_comb
  begin
    case (wdata_shift)
      2'b00:   wdata_o = data_wdata_i;                                // already in place
      2'b01:   wdata_o = {data_wdata_i[23:0], data_wdata_i[31:24]};   // one lane up
      2'b10:   wdata_o = {data_wdata_i[15:0], data_wdata_i[31:16]};   // swap halves
      2'b11:   wdata_o = {data_wdata_i[7:0],  data_wdata_i[31:8]};    // three lanes up
      default: wdata_o = data_wdata_i;
    endcase
  end

endmodule

`default_nettype wire

/* hw/lsu_txn_tracker.sv */
`default_nettype none
`timescale 1ns/1ns

`include "lsu_macros.svh"

module lsu_txn_tracker (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               data_req_i,      // EX stage wants a transfer
  input  wire logic               data_we_i,
  input  wire lsu_pkg::lsu_type_e data_type_i,
  input  wire lsu_pkg::lsu_ext_e  data_sign_ext_i,
  input  wire logic [1:0]         addr_lsb_i,      // byte offset of the current address
  input  wire logic               data_gnt_i,
  input  wire logic               data_rvalid_i,
  output logic                    trans_valid_o,   // becomes data_req_o
  output logic                    ready_ex_o,
  output logic                    ready_wb_o,
  output logic                    busy_o,
  output lsu_pkg::lsu_type_e      wb_type_o,       // WB control of the oldest open transfer
  output lsu_pkg::lsu_ext_e       wb_sign_ext_o,
  output logic [1:0]              wb_offset_o,
  output logic                    wb_we_o
);

  import lsu_pkg::*;

  logic [1:0] cnt_q;        // transfers granted but not yet answered
  logic [1:0] cnt_d;
  logic       count_up;     // accepted address phase
  logic       count_down;   // response seen
  logic       ctrl_update;  // EX hands its access over to WB

  ////////////////////////////////////////////////////////////
  // request gating and outstanding count
  ////////////////////////////////////////////////////////////

  // no path from rvalid to req, only the registered count gates it
  assign trans_valid_o = data_req_i && (cnt_q < 2'(`LSU_DEPTH));

  assign count_up   = trans_valid_o && data_gnt_i;
  assign count_down = data_rvalid_i;

  always_comb
  begin
    case ({count_up, count_down})
      2'b10:   cnt_d = cnt_q + 2'd1;
      2'b01:   cnt_d = cnt_q - 2'd1;
      default: cnt_d = cnt_q;         // idle, or one in while one leaves
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      cnt_q <= '0;
    else
      cnt_q <= cnt_d;
  end

  ////////////////////////////////////////////////////////////
  // ready and busy
  ////////////////////////////////////////////////////////////

  assign ready_wb_o = (cnt_q == 2'd0) ? 1'b1 : data_rvalid_i;  // WB free or freeing now

  // EX and WB move in lock step once WB is occupied
  assign ready_ex_o = !data_req_i      ? 1'b1 :
                      (cnt_q == 2'd0)  ? count_up :
                      (cnt_q == 2'd1)  ? (count_up && data_rvalid_i) :
                                         data_rvalid_i;

  assign busy_o = (cnt_q != 2'd0) || trans_valid_o;

  ////////////////////////////////////////////////////////////
  // WB control registers
  ////////////////////////////////////////////////////////////

  assign ctrl_update = ready_ex_o && data_req_i;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      wb_type_o     <= LSU_WORD;
      wb_sign_ext_o <= LSU_EXT_ZERO;
      wb_offset_o   <= '0;
      wb_we_o       <= 1'b0;
    end
    else if (ctrl_update)  // access leaves EX, its response is the next one
    begin
      wb_type_o     <= data_type_i;
      wb_sign_ext_o <= data_sign_ext_i;
      wb_offset_o   <= addr_lsb_i;
      wb_we_o       <= data_we_i;
    end
  end

  // count stays within the configured depth
  a_cnt_depth: assert property (@(posedge clk) disable iff (!rst_n)
    cnt_q <= 2'(`LSU_DEPTH));

  // every response belongs to a granted transfer
  a_no_stray_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    data_rvalid_i |-> (cnt_q != 2'd0));

  // misaligned accesses are not supported by the builder
  a_aligned_req: assert property (@(posedge clk) disable iff (!rst_n)
    data_req_i |-> !((data_type_i == LSU_WORD) && (addr_lsb_i != 2'b00)) &&
                   !((data_type_i == LSU_HALF) && (addr_lsb_i == 2'b11)));

endmodule

`default_nettype wire

/* hw/lsu_load_aligner.sv */
`default_nettype none
`timescale 1ns/1ns

`include "lsu_macros.svh"

module lsu_load_aligner (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 resp_valid_i,   // bus response this cycle
  input  wire logic [`LSU_XLEN-1:0] resp_rdata_i,   // raw response word
  input  wire lsu_pkg::lsu_type_e   wb_type_i,
  input  wire lsu_pkg::lsu_ext_e    wb_sign_ext_i,
  input  wire logic [1:0]           wb_offset_i,    // byte offset of the load
  input  wire logic                 wb_we_i,        // response belongs to a store
  output logic      [`LSU_XLEN-1:0] rdata_o,        // to the register file
  output logic                      load_valid_o
);

  import lsu_pkg::*;

  lsu_word_u              resp_word;   // byte and halfword views of the response
  logic [7:0]             byte_sel;
  logic [15:0]            half_sel;
  logic                   sign_bit;    // msb of the selected field
  logic                   fill;        // bit used above the selected field
  logic [`LSU_XLEN-1:0]   rdata_ext;   // aligned and extended load value
  logic [`LSU_XLEN-1:0]   rdata_q;     // last load result

  ////////////////////////////////////////////////////////////
  // lane select
  ////////////////////////////////////////////////////////////

  assign resp_word = resp_rdata_i;
  assign byte_sel  = resp_word.b[wb_offset_i];     // any of the four lanes
  assign half_sel  = resp_word.h[wb_offset_i[1]];  // offset 0 or 2 only

  ////////////////////////////////////////////////////////////
  // extension
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    sign_bit = (wb_type_i == LSU_HALF) ? half_sel[15] : byte_sel[7];

    case (wb_sign_ext_i)
      LSU_EXT_ZERO:     fill = 1'b0;
      LSU_EXT_ONES:     fill = 1'b1;
      LSU_EXT_SIGN,
      LSU_EXT_SIGN_ALT: fill = sign_bit;
      default:          fill = 1'b0;
    endcase

    case (wb_type_i)
      LSU_WORD:     rdata_ext = resp_rdata_i;                        // passes whole
      LSU_HALF:     rdata_ext = {{(`LSU_XLEN-16){fill}}, half_sel};
      LSU_BYTE,
      LSU_BYTE_ALT: rdata_ext = {{(`LSU_XLEN-8){fill}}, byte_sel};
      default:      rdata_ext = resp_rdata_i;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // hold register and output mux
  ////////////////////////////////////////////////////////////

  assign load_valid_o = resp_valid_i && !wb_we_i;  // store responses carry no data

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      rdata_q <= '0;
    else if (load_valid_o)
      rdata_q <= rdata_ext;   // keep result for a stalled WB
  end

  assign rdata_o = load_valid_o ? rdata_ext : rdata_q;

endmodule

`default_nettype wire

/* hw/lsu_top.sv */
`default_nettype none
`timescale 1ns/1ns

`include "lsu_macros.svh"

module lsu_top (
  input  wire logic                   clk,
  input  wire logic                   rst_n,

  // EX stage
  input  wire logic                   data_req_ex_i,
  input  wire logic                   data_we_ex_i,
  input  wire lsu_pkg::lsu_type_e     data_type_ex_i,
  input  wire lsu_pkg::lsu_ext_e      data_sign_ext_ex_i,
  input  wire logic [`LSU_XLEN-1:0]   data_wdata_ex_i,
  input  wire logic [1:0]             data_reg_offset_ex_i,
  input  wire logic [`LSU_XLEN-1:0]   operand_a_ex_i,
  input  wire logic [`LSU_XLEN-1:0]   operand_b_ex_i,
  input  wire logic                   addr_useincr_ex_i,
  output logic      [`LSU_XLEN-1:0]   data_rdata_ex_o,   // load result to WB
  output logic                        load_valid_o,
  output logic                        lsu_ready_ex_o,
  output logic                        lsu_ready_wb_o,
  output logic                        busy_o,

  // data bus
  output logic                        data_req_o,
  input  wire logic                   data_gnt_i,
  output logic      [`LSU_XLEN-1:0]   data_addr_o,
  output logic                        data_we_o,
  output logic      [`LSU_NBYTES-1:0] data_be_o,
  output logic      [`LSU_XLEN-1:0]   data_wdata_o,
  input  wire logic                   data_rvalid_i,
  input  wire logic [`LSU_XLEN-1:0]   data_rdata_i
);

  import lsu_pkg::*;

  // WB control, tracker to aligner
  lsu_type_e  wb_type;
  lsu_ext_e   wb_sign_ext;
  logic [1:0] wb_offset;
  logic       wb_we;

  assign data_we_o = data_we_ex_i;  // direction goes straight out with the address phase

  ////////////////////////////////////////////////////////////
  // address phase
  ////////////////////////////////////////////////////////////

  lsu_req_builder req_builder_i (
    .operand_a_i       (operand_a_ex_i),
    .operand_b_i       (operand_b_ex_i),
    .addr_useincr_i    (addr_useincr_ex_i),
    .data_type_i       (data_type_ex_i),
    .data_wdata_i      (data_wdata_ex_i),
    .data_reg_offset_i (data_reg_offset_ex_i),
    .addr_o            (data_addr_o),
    .be_o              (data_be_o),
    .wdata_o           (data_wdata_o)
  );

  lsu_txn_tracker txn_tracker_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .data_req_i      (data_req_ex_i),
    .data_we_i       (data_we_ex_i),
    .data_type_i     (data_type_ex_i),
    .data_sign_ext_i (data_sign_ext_ex_i),
    .addr_lsb_i      (data_addr_o[1:0]),   // low bits from the builder
    .data_gnt_i      (data_gnt_i),
    .data_rvalid_i   (data_rvalid_i),
    .trans_valid_o   (data_req_o),
    .ready_ex_o      (lsu_ready_ex_o),
    .ready_wb_o      (lsu_ready_wb_o),
    .busy_o          (busy_o),
    .wb_type_o       (wb_type),
    .wb_sign_ext_o   (wb_sign_ext),
    .wb_offset_o     (wb_offset),
    .wb_we_o         (wb_we)
  );

  ////////////////////////////////////////////////////////////
  // response phase
  ////////////////////////////////////////////////////////////

  lsu_load_aligner load_aligner_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .resp_valid_i  (data_rvalid_i),
    .resp_rdata_i  (data_rdata_i),
    .wb_type_i     (wb_type),
    .wb_sign_ext_i (wb_sign_ext),
    .wb_offset_i   (wb_offset),
    .wb_we_i       (wb_we),
    .rdata_o       (data_rdata_ex_o),
    .load_valid_o  (load_valid_o)
  );

endmodule

`default_nettype wire

/* testbench/tb_lsu_mem.sv */
`default_nettype none
`timescale 1ns/1ns

`include "lsu_macros.svh"

module tb_lsu_mem (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   req_i,       // address phase from the LSU
  output logic                        gnt_o,
  input  wire logic [`LSU_XLEN-1:0]   addr_i,
  input  wire logic                   we_i,
  input  wire logic [`LSU_NBYTES-1:0] be_i,
  input  wire logic [`LSU_XLEN-1:0]   wdata_i,
  output logic                        rvalid_o,    // one pulse per accepted transfer
  output logic      [`LSU_XLEN-1:0]   rdata_o,
  input  wire logic                   rand_en_i,   // 1: delays drawn up to the limits
  input  wire logic [3:0]             gnt_dly_i,   // grant wait, or its upper limit
  input  wire logic [3:0]             rsp_dly_i    // extra response wait, or its limit
);

  logic [`LSU_XLEN-1:0] mem [0:255];   // 1 KiB, word indexed
  logic [`LSU_XLEN-1:0] rsp_data_q [$];  // responses in grant order
  int                   rsp_wait_q [$];
  int                   seed;
  int                   gnt_wait;    // cycles the current request has waited
  int                   gnt_need;    // wait this request needs for its grant

  function automatic int draw_delay(input logic [3:0] lim);
    if (rand_en_i)
      return $unsigned($random(seed)) % (int'(lim) + 1);
    return int'(lim);
  endfunction

  initial
  begin
    seed = 42823;
    for (int i = 0; i < 256; i++)
      mem[i] = {8'(i), 8'(~i), 8'(i * 7), 8'(i ^ 8'h3c)};  // each byte tied to the index
  end

  assign gnt_o = req_i && (gnt_wait >= gnt_need);

  always @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
      gnt_wait <= 0;
      gnt_need <= 0;
      rsp_data_q.delete();
      rsp_wait_q.delete();
    end
    else
    begin
      // address phase, writes land at accept time so later reads see them
      if (req_i && gnt_o)
      begin
        for (int k = 0; k < `LSU_NBYTES; k++)
          if (we_i && be_i[k])
            mem[addr_i[9:2]][8*k +: 8] = wdata_i[8*k +: 8];
        rsp_data_q.push_back(mem[addr_i[9:2]]);
        rsp_wait_q.push_back(draw_delay(rsp_dly_i));
        gnt_wait <= 0;
        gnt_need <= draw_delay(gnt_dly_i);
      end
      else if (req_i)
        gnt_wait <= gnt_wait + 1;           // still stalled
      else
        gnt_need <= draw_delay(gnt_dly_i);  // idle, new settings apply here

      // response phase, head of the queue only
      if ((rsp_wait_q.size() != 0) && (rsp_wait_q[0] == 0))
      begin
        rvalid_o <= 1'b1;
        rdata_o  <= rsp_data_q.pop_front();
        void'(rsp_wait_q.pop_front());
      end
      else
      begin
        rvalid_o <= 1'b0;
        if (rsp_wait_q.size() != 0)
          rsp_wait_q[0] = rsp_wait_q[0] - 1;
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/tb_lsu.sv */
`default_nettype none
`timescale 1ns/1ns

`include "lsu_macros.svh"

module tb_lsu;

  import lsu_pkg::*;

  localparam int EXP_BE      = 0;    // lsu_expect result kinds
  localparam int EXP_WDATA   = 1;
  localparam int EXP_LOAD    = 2;
  localparam int ISSUE_LIMIT = 64;   // cycles until the EX side is released
  localparam int DRAIN_LIMIT = 128;  // cycles until busy drops

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic                   data_req_ex_i;
  logic                   data_we_ex_i;
  lsu_type_e              data_type_ex_i;
  lsu_ext_e               data_sign_ext_ex_i;
  logic [`LSU_XLEN-1:0]   data_wdata_ex_i;
  logic [1:0]             data_reg_offset_ex_i;
  logic [`LSU_XLEN-1:0]   operand_a_ex_i;
  logic [`LSU_XLEN-1:0]   operand_b_ex_i;
  logic                   addr_useincr_ex_i;
  logic [`LSU_XLEN-1:0]   data_rdata_ex_o;
  logic                   load_valid_o;
  logic                   lsu_ready_ex_o;
  logic                   lsu_ready_wb_o;
  logic                   busy_o;
  logic                   data_req_o;
  logic                   data_gnt_i;
  logic [`LSU_XLEN-1:0]   data_addr_o;
  logic                   data_we_o;
  logic [`LSU_NBYTES-1:0] data_be_o;
  logic [`LSU_XLEN-1:0]   data_wdata_o;
  logic                   data_rvalid_i;
  logic [`LSU_XLEN-1:0]   data_rdata_i;
  logic                   rand_en;     // memory delay settings
  logic [3:0]             gnt_dly;
  logic [3:0]             rsp_dly;

  int                   seed;
  int                   errors = 0;
  int                   tests = 0;
  int                   failed_tests = 0;
  int                   test_err0;     // error count when the test started
  string                test_name;
  int                   stall_cycles;  // req without grant, last access
  int                   open_cnt = 0;  // granted minus answered, seen from the bus
  int                   max_open = 0;
  logic [`LSU_XLEN-1:0] load_q [$];    // expected load results in order
  logic [`LSU_XLEN-1:0] last_load = '0;
  logic [`LSU_XLEN-1:0] load_exp;

  always #10 clk = ~clk;  // 20 ns

  lsu_top dut_i (
    .clk                  (clk),
    .rst_n                (rst_n),
    .data_req_ex_i        (data_req_ex_i),
    .data_we_ex_i         (data_we_ex_i),
    .data_type_ex_i       (data_type_ex_i),
    .data_sign_ext_ex_i   (data_sign_ext_ex_i),
    .data_wdata_ex_i      (data_wdata_ex_i),
    .data_reg_offset_ex_i (data_reg_offset_ex_i),
    .operand_a_ex_i       (operand_a_ex_i),
    .operand_b_ex_i       (operand_b_ex_i),
    .addr_useincr_ex_i    (addr_useincr_ex_i),
    .data_rdata_ex_o      (data_rdata_ex_o),
    .load_valid_o         (load_valid_o),
    .lsu_ready_ex_o       (lsu_ready_ex_o),
    .lsu_ready_wb_o       (lsu_ready_wb_o),
    .busy_o               (busy_o),
    .data_req_o           (data_req_o),
    .data_gnt_i           (data_gnt_i),
    .data_addr_o          (data_addr_o),
    .data_we_o            (data_we_o),
    .data_be_o            (data_be_o),
    .data_wdata_o         (data_wdata_o),
    .data_rvalid_i        (data_rvalid_i),
    .data_rdata_i         (data_rdata_i)
  );

  tb_lsu_mem mem_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_i     (data_req_o),
    .gnt_o     (data_gnt_i),
    .addr_i    (data_addr_o),
    .we_i      (data_we_o),
    .be_i      (data_be_o),
    .wdata_i   (data_wdata_o),
    .rvalid_o  (data_rvalid_i),
    .rdata_o   (data_rdata_i),
    .rand_en_i (rand_en),
    .gnt_dly_i (gnt_dly),
    .rsp_dly_i (rsp_dly)
  );

  //////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////

  function automatic logic [`LSU_XLEN-1:0] lsu_expect(input int what, input lsu_type_e t,
      input logic [1:0] off, input logic [1:0] reg_off, input lsu_ext_e ext,
      input logic [`LSU_XLEN-1:0] data);
    logic [`LSU_XLEN-1:0] res;
    int                   nbytes;  // bytes the access covers
    int                   src;
    logic                 fill;
    res    = '0;
    nbytes = (t == LSU_WORD) ? 4 : (t == LSU_HALF) ? 2 : 1;
    case (what)
      EXP_BE:
      begin
        for (int i = 0; i < `LSU_NBYTES; i++)
          res[i] = (i >= int'(off)) && (i < int'(off) + nbytes);
      end
      EXP_WDATA:
      begin
        // register byte reg_off must end up in lane off
        for (int i = 0; i < `LSU_NBYTES; i++)
        begin
          src = (i - int'(off) + int'(reg_off)) & 3;
          res[8*i +: 8] = data[8*src +: 8];
        end
      end
      default:
      begin
        if (t == LSU_HALF)
          res = data >> (16 * int'(off[1]));  // halfword lane off/2
        else if (t != LSU_WORD)
          res = data >> (8 * int'(off));
        else
          res = data;
        fill = (ext == LSU_EXT_ZERO) ? 1'b0 :
               (ext == LSU_EXT_ONES) ? 1'b1 : res[8*nbytes-1];
        for (int i = 8 * nbytes; i < `LSU_XLEN; i++)
          res[i] = fill;  // nothing to do for a word
      end
    endcase
    return res;
  endfunction

  //////////////////////////////////////////////////////////////
  // compare and report
  //////////////////////////////////////////////////////////////

  task automatic check_word(input logic [`LSU_XLEN-1:0] act, input logic [`LSU_XLEN-1:0] exp,
      input string what);
    if (act !== exp)
    begin
      errors++;
      $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, act, exp);
    end
  endtask

  task automatic check_be(input logic [`LSU_NBYTES-1:0] act,
      input logic [`LSU_NBYTES-1:0] exp, input string what);
    if (act !== exp)
    begin
      errors++;
      $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, act, exp);
    end
  endtask

  task automatic check_bit(input logic act, input logic exp, input string what);
    if (act !== exp)
    begin
      errors++;
      $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, act, exp);
    end
  endtask

  task automatic note_error(input string what);
    errors++;
    $display("error at %0t ns: %s", $time, what);
  endtask

  task automatic timeout_abort(input string what);
    $display("timeout at %0t ns: %s", $time, what);
    $display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
    $display("Testbench failed");
    $finish;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_err0 = errors;
  endtask

  task automatic end_test();
    tests++;
    if (errors == test_err0)
      $display("test %0d %s: ok", tests, test_name);
    else
    begin
      failed_tests++;
      $display("test %0d %s: %0d errors", tests, test_name, errors - test_err0);
    end
  endtask

  //////////////////////////////////////////////////////////////
  // EX side driver
  //////////////////////////////////////////////////////////////

  task automatic set_delays(input logic rnd, input logic [3:0] g, input logic [3:0] r);
    rand_en <= rnd;
    gnt_dly <= g;
    rsp_dly <= r;
    @(posedge clk);  // memory takes them while idle
  endtask

  // present one access and hold it until EX is released
  task automatic issue(input logic we, input lsu_type_e t, input lsu_ext_e ext,
      input logic [1:0] reg_off, input logic [`LSU_XLEN-1:0] wdata,
      input logic [`LSU_XLEN-1:0] a, input logic [`LSU_XLEN-1:0] b, input logic incr,
      input logic [`LSU_XLEN-1:0] mem_word);
    logic [`LSU_XLEN-1:0] addr;
    logic [`LSU_XLEN-1:0] be_w;
    logic [`LSU_XLEN-1:0] wdata_exp;
    logic                 granted;
    logic                 pending;  // waited for a grant last cycle
    int                   n;
    addr      = incr ? (a + b) : a;
    be_w      = lsu_expect(EXP_BE, t, addr[1:0], reg_off, ext, wdata);
    wdata_exp = lsu_expect(EXP_WDATA, t, addr[1:0], reg_off, ext, wdata);
    granted      = 1'b0;
    pending      = 1'b0;
    n            = 0;
    stall_cycles = 0;
    data_req_ex_i        <= 1'b1;
    data_we_ex_i         <= we;
    data_type_ex_i       <= t;
    data_sign_ext_ex_i   <= ext;
    data_wdata_ex_i      <= wdata;
    data_reg_offset_ex_i <= reg_off;
    operand_a_ex_i       <= a;
    operand_b_ex_i       <= b;
    addr_useincr_ex_i    <= incr;
    if (!we)
      load_q.push_back(lsu_expect(EXP_LOAD, t, addr[1:0], reg_off, ext, mem_word));
    do
    begin
      @(posedge clk);
      n++;
      if (data_req_o)
      begin
        if (granted)
          note_error("bus request repeated after its grant");
        check_word(data_addr_o, addr, "bus address");
        check_be(data_be_o, be_w[`LSU_NBYTES-1:0], "byte enables");
        check_bit(data_we_o, we, "bus write enable");
        if (we)
          check_word(data_wdata_o, wdata_exp, "bus write data");
        if (data_gnt_i)
          granted = 1'b1;
        else
        begin
          check_bit(lsu_ready_ex_o, 1'b0, "EX ready before grant");
          stall_cycles++;
        end
      end
      else if (pending)
        note_error("bus request dropped before its grant");
      pending = data_req_o && !data_gnt_i;
    end
    while (!lsu_ready_ex_o && (n < ISSUE_LIMIT));
    if (lsu_ready_ex_o)
      check_bit(granted, 1'b1, "grant seen when EX released");
    else
      timeout_abort("EX side never got ready");
  endtask

  task automatic drain();
    int n;
    n = 0;
    data_req_ex_i <= 1'b0;
    do
    begin
      @(posedge clk);
      n++;
    end
    while ((busy_o || (load_q.size() != 0)) && (n < DRAIN_LIMIT));
    if (busy_o || (load_q.size() != 0))
      timeout_abort("transfers still open");
  endtask

  //////////////////////////////////////////////////////////////
  // response and occupancy monitor
  //////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    if (rst_n)
    begin
      if (load_valid_o)
      begin
        if (load_q.size() == 0)
          note_error("load response with no load open");
        else
        begin
          load_exp = load_q.pop_front();
          check_word(data_rdata_ex_o, load_exp, "load data");
          last_load = load_exp;
        end
      end
      else
        check_word(data_rdata_ex_o, last_load, "held load data");  // stays put between loads
      if (open_cnt >= `LSU_DEPTH)
        check_bit(data_req_o, 1'b0, "bus request with two open");
      check_bit(busy_o, (open_cnt != 0) || data_req_ex_i, "busy");  // open or requested
      check_bit(lsu_ready_wb_o, (open_cnt == 0) || data_rvalid_i, "WB ready");
      open_cnt = open_cnt + ((data_req_o && data_gnt_i) ? 1 : 0) - (data_rvalid_i ? 1 : 0);
      if (open_cnt > max_open)
        max_open = open_cnt;
    end
  end

  //////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////

  initial
  begin
    logic [`LSU_XLEN-1:0] words [3];
    seed = 42823;
    rst_n                <= 1'b0;
    data_req_ex_i        <= 1'b0;
    data_we_ex_i         <= 1'b0;
    data_type_ex_i       <= LSU_WORD;
    data_sign_ext_ex_i   <= LSU_EXT_ZERO;
    data_wdata_ex_i      <= '0;
    data_reg_offset_ex_i <= '0;
    operand_a_ex_i       <= '0;
    operand_b_ex_i       <= '0;
    addr_useincr_ex_i    <= 1'b0;
    rand_en              <= 1'b0;
    gnt_dly              <= '0;
    rsp_dly              <= '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    start_test("reset state");
    check_bit(data_req_o, 1'b0, "data_req_o");
    check_bit(busy_o, 1'b0, "busy_o");
    check_bit(load_valid_o, 1'b0, "load_valid_o");
    check_bit(lsu_ready_ex_o, 1'b1, "lsu_ready_ex_o");
    check_bit(lsu_ready_wb_o, 1'b1, "lsu_ready_wb_o");
    check_word(data_rdata_ex_o, '0, "data_rdata_ex_o");
    end_test();

    start_test("word store a+b");
    set_delays(1'b0, 4'd0, 4'd0);
    issue(1'b1, LSU_WORD, LSU_EXT_ZERO, 2'd0, 32'hdeadbeef, 32'h100, 32'h20, 1'b1, '0);
    drain();
    end_test();

    start_test("sub-word stores");
    set_delays(1'b1, 4'd2, 4'd2);
    for (int t = 1; t < 4; t++)      // half and both byte codes
      for (int off = 0; off < 4; off++)
        for (int roff = 0; roff < 4; roff++)
          if (!((t == 1) && (off == 3)))
            issue(1'b1, lsu_type_e'(t), LSU_EXT_ZERO, 2'(roff), $random(seed),
                  32'h200 + off, '0, 1'b0, '0);
    drain();
    end_test();

    start_test("loads");
    words[0] = 32'h8f70e15a;  // sign bits set in some lanes
    words[1] = 32'h7f80017e;
    words[2] = $random(seed);
    set_delays(1'b1, 4'd1, 4'd3);
    foreach (words[i])
    begin
      issue(1'b1, LSU_WORD, LSU_EXT_ZERO, 2'd0, words[i], 32'h300, '0, 1'b0, '0);
      for (int t = 0; t < 4; t++)
        for (int off = 0; off < 4; off++)
          for (int e = 0; e < 4; e++)
            if (!((t == 0) && (off != 0)) && !((t == 1) && (off == 3)))
              issue(1'b0, lsu_type_e'(t), lsu_ext_e'(e), 2'd0, '0, 32'h300, off, 1'b1,
                    words[i]);
    end
    drain();
    end_test();

    start_test("back-pressure");
    set_delays(1'b0, 4'd5, 4'd0);
    issue(1'b1, LSU_WORD, LSU_EXT_ZERO, 2'd0, 32'hc0ffee11, 32'h340, '0, 1'b0, '0);
    check_word(32'(stall_cycles), 32'd5, "store grant wait");
    issue(1'b0, LSU_WORD, LSU_EXT_ZERO, 2'd0, '0, 32'h340, '0, 1'b0, 32'hc0ffee11);
    check_word(32'(stall_cycles), 32'd5, "load grant wait");
    drain();
    end_test();

    start_test("pipelining");
    set_delays(1'b0, 4'd0, 4'd6);
    max_open = 0;
    issue(1'b0, LSU_HALF, LSU_EXT_SIGN, 2'd0, '0, 32'h340, '0, 1'b0, 32'hc0ffee11);
    issue(1'b0, LSU_HALF, LSU_EXT_SIGN, 2'd0, '0, 32'h342, '0, 1'b0, 32'hc0ffee11);
    issue(1'b0, LSU_BYTE, LSU_EXT_ONES, 2'd0, '0, 32'h343, '0, 1'b0, 32'hc0ffee11);
    drain();
    check_word(32'(max_open), 32'(`LSU_DEPTH), "transfers open at once");
    end_test();

    $display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hw
hw/lsu_pkg.sv
hw/lsu_req_builder.sv
hw/lsu_txn_tracker.sv
hw/lsu_load_aligner.sv
hw/lsu_top.sv
testbench/tb_lsu_mem.sv
testbench/tb_lsu.sv

/* Bender.yml */
package:
  name: lsu

sources:
  - include_dirs:
      - hw
    files:
      - hw/lsu_pkg.sv
      - hw/lsu_req_builder.sv
      - hw/lsu_txn_tracker.sv
      - hw/lsu_load_aligner.sv
      - hw/lsu_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/tb_lsu_mem.sv
      - testbench/tb_lsu.sv
